//--- filelist.f
+incdir+include
hw/accel_pkg.sv
hw/accel_mul.sv
hw/accel_cr_mem.sv
hw/accel_top.sv
sim/accel_tb.sv

//--- hw/accel_cr_mem.sv
/*
 * Accelerator CR memory
 * Flop-based control registers between the core register bus
 * and the multiplier farm. Request CRs are written by the core
 * and drive the units directly. Status CRs sample the unit
 * responses every cycle. Reads return a registered word on q.
 */

`timescale 1ns/1ps

`include "accel_consts.svh"

module accel_cr_mem (
    input  logic                     Clk,
    input  logic                     rst_n,

    // Core register bus
    input  logic [31:0]              data,
    input  logic [31:0]              address,
    input  logic                     wren,
    input  logic                     rden,
    output logic [31:0]              q,

    // Multiplier farm
    input  accel_pkg::t_mul2core_rsp mul2core_rsp,
    output accel_pkg::t_core2mul_req core2mul_req
);

    // Current and next CR image
    accel_pkg::t_accel_cr accel_cr;
    accel_pkg::t_accel_cr next_accel_cr;

    // Read data before the output flop
    logic [31:0] pre_q;

    // --------------------
    // Write path
    // --------------------

    always_comb begin : wr_to_accel_cr
        next_accel_cr = accel_cr;

        // Core writes land only in request CRs
        if (wren) begin
            for (int i = 0; i < `ACCEL_NUM_MUL; i++) begin
                if (address == 32'(`CR_CORE2MUL_BASE + `CR_STRIDE * i)) begin
                    // Keep start, multiplicand and multiplier
                    next_accel_cr.cr_core2mul[i] = data[`REQ_START_BIT:0];
                end
            end
        end

        // Status CRs follow the units every cycle
        for (int i = 0; i < `ACCEL_NUM_MUL; i++) begin
            next_accel_cr.cr_mul2core[i][`RSP_BUSY_BIT]      = mul2core_rsp[i].busy;
            next_accel_cr.cr_mul2core[i][`RSP_VALID_BIT]     = mul2core_rsp[i].valid;
            next_accel_cr.cr_mul2core[i][`RSP_VALID_BIT-1:0] = mul2core_rsp[i].result;
        end
    end

    // CR flops
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            // All starts low after reset
            accel_cr <= '0;
        end else begin
            accel_cr <= next_accel_cr;
        end
    end

    // --------------------
    // Read path
    // --------------------

    always_comb begin : rd_from_accel_cr
        // Unmapped address or no read gives zero
        pre_q = '0;

        if (rden) begin
            for (int i = 0; i < `ACCEL_NUM_MUL; i++) begin
                // Request CR read-back
                if (address == 32'(`CR_CORE2MUL_BASE + `CR_STRIDE * i)) begin
                    pre_q = 32'(accel_cr.cr_core2mul[i]);
                end

                // Status CR read
                if (address == 32'(`CR_MUL2CORE_BASE + `CR_STRIDE * i)) begin
                    pre_q = 32'(accel_cr.cr_mul2core[i]);
                end
            end
        end
    end

    // Registered read data, valid the cycle after rden
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            q <= '0;
        end else begin
            q <= pre_q;
        end
    end

    // --------------------
    // Request bundle
    // --------------------

    // Straight from the request CRs, no extra delay
    always_comb begin : cr_to_req
        for (int i = 0; i < `ACCEL_NUM_MUL; i++) begin
            core2mul_req[i].valid =
                accel_cr.cr_core2mul[i][`REQ_START_BIT];
            core2mul_req[i].multiplicand =
                accel_cr.cr_core2mul[i][`REQ_MCAND_MSB:`REQ_MCAND_LSB];
            core2mul_req[i].multiplier =
                accel_cr.cr_core2mul[i][`REQ_MPLIER_MSB:0];
        end
    end

endmodule

//--- hw/accel_mul.sv
/*
 * Sequential 8x8 multiplier
 * Unsigned shift-add unit. A rising start level loads the operands,
 * busy is held for a fixed number of steps, then the product is
 * held with valid set until the next start.
 */

`timescale 1ns/1ps

`include "accel_consts.svh"

module accel_mul (
    input  logic                 Clk,
    input  logic                 rst_n,
    input  accel_pkg::t_core2mul req,
    output accel_pkg::t_mul2core rsp
);

    // Step counter width
    localparam int CNT_W = $clog2(`MUL_STEPS);

    // Start edge detection
    logic             start_q;
    logic             start_edge;

    // Control state
    logic             busy;
    logic             valid;
    logic [CNT_W-1:0] step_cnt;
    logic             last_step;

    // Datapath
    logic [15:0]      mcand_sh;
    logic [7:0]       mplier_sh;
    logic [15:0]      acc;
    logic [15:0]      acc_sum;

    // --------------------
    // Start detection
    // --------------------

    // Previous start level
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            start_q <= 1'b0;
        end else begin
            start_q <= req.valid;
        end
    end

    // Low to high on the request valid
    assign start_edge = req.valid & ~start_q;

    // --------------------
    // Shift-add datapath
    // --------------------

    // Add the shifted multiplicand when the multiplier bit is set
    assign acc_sum   = mplier_sh[0] ? (acc + mcand_sh) : acc;
    assign last_step = (step_cnt == CNT_W'(`MUL_STEPS - 1));

    // Operand shifters
    always_ff @(posedge Clk) begin
        if (start_edge && !busy) begin
            mcand_sh  <= {8'h00, req.multiplicand};
            mplier_sh <= req.multiplier;
        end else if (busy) begin
            mcand_sh  <= mcand_sh << 1;
            mplier_sh <= mplier_sh >> 1;
        end
    end

    // Control and accumulator
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            valid    <= 1'b0;
            step_cnt <= '0;
            acc      <= '0;
        end else if (start_edge && !busy) begin
            // Fresh product, old result dropped
            busy     <= 1'b1;
            valid    <= 1'b0;
            step_cnt <= '0;
            acc      <= '0;
        end else if (busy) begin
            acc      <= acc_sum;
            step_cnt <= step_cnt + 1'b1;
            // Done in the same cycle busy falls
            if (last_step) begin
                busy  <= 1'b0;
                valid <= 1'b1;
            end
        end
    end

    // --------------------
    // Response
    // --------------------

    // Accumulator holds the product after the last step
    assign rsp.busy   = busy;
    assign rsp.valid  = valid;
    assign rsp.result = acc;

endmodule

//--- hw/accel_pkg.sv
/*
 * Accelerator farm package
 * Packed struct types for the per-unit request and response,
 * the eight-unit bundles, and the flop-based CR image
 */

`include "accel_consts.svh"

package accel_pkg;

    // --------------------
    // Per-unit types
    // --------------------

    // One request, same bit order as the request word
    typedef struct packed {
        logic       valid;
        logic [7:0] multiplicand;
        logic [7:0] multiplier;
    } t_core2mul;

    // One response, same bit order as the status word
    typedef struct packed {
        logic        busy;
        logic        valid;
        logic [15:0] result;
    } t_mul2core;

    // --------------------
    // Farm bundles
    // --------------------

    // Entry i belongs to multiplier unit i
    typedef t_core2mul [`ACCEL_NUM_MUL-1:0] t_core2mul_req;
    typedef t_mul2core [`ACCEL_NUM_MUL-1:0] t_mul2core_rsp;

    // --------------------
    // CR image
    // --------------------

    // Raw request and status words as seen by the core
    typedef struct packed {
        logic [`ACCEL_NUM_MUL-1:0][`REQ_START_BIT:0] cr_core2mul;
        logic [`ACCEL_NUM_MUL-1:0][`RSP_BUSY_BIT:0]  cr_mul2core;
    } t_accel_cr;

endpackage

//--- hw/accel_top.sv
/*
 * Accelerator farm top
 * Joins the CR memory on the core register bus to eight
 * sequential multiplier units
 */

`timescale 1ns/1ps

`include "accel_consts.svh"

module accel_top (
    input  logic        Clk,
    input  logic        rst_n,

    // Core register bus
    input  logic [31:0] data,
    input  logic [31:0] address,
    input  logic        wren,
    input  logic        rden,
    output logic [31:0] q
);

    // --------------------
    // Farm bundles
    // --------------------

    // Request CRs out to the units
    accel_pkg::t_core2mul_req core2mul_req;

    // Unit responses back to the status CRs
    accel_pkg::t_mul2core_rsp mul2core_rsp;

    // --------------------
    // CR memory
    // --------------------

    accel_cr_mem i_accel_cr_mem (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .data         (data),
        .address      (address),
        .wren         (wren),
        .rden         (rden),
        .q            (q),
        .mul2core_rsp (mul2core_rsp),
        .core2mul_req (core2mul_req)
    );

    // --------------------
    // Multiplier units
    // --------------------

    // One unit per request and status CR pair
    for (genvar i = 0; i < `ACCEL_NUM_MUL; i++) begin : g_mul
        accel_mul i_accel_mul (
            .Clk   (Clk),
            .rst_n (rst_n),
            .req   (core2mul_req[i]),
            .rsp   (mul2core_rsp[i])
        );
    end

endmodule

//--- include/accel_consts.svh
/*
 * Accelerator farm constants
 * CR address map, unit count, field positions of the request and
 * status words, and the shift-add iteration count
 */

`ifndef ACCEL_CONSTS_SVH
`define ACCEL_CONSTS_SVH

// --------------------
// Farm size
// --------------------
`define ACCEL_NUM_MUL       8

// --------------------
// CR address map
// --------------------
// Byte addresses, one 32-bit word per CR
`define CR_CORE2MUL_BASE    32'h0000_0000
`define CR_MUL2CORE_BASE    32'h0000_0040
`define CR_STRIDE           4

// Request word {start, multiplicand, multiplier}
`define REQ_START_BIT       16
`define REQ_MCAND_MSB       15
`define REQ_MCAND_LSB       8
`define REQ_MPLIER_MSB      7

// Status word {busy, valid, product}
`define RSP_BUSY_BIT        17
`define RSP_VALID_BIT       16

// Shift-add iterations per product
`define MUL_STEPS           8

`endif

//--- include/accel_tb_checks.svh
/*
 * Accelerator farm testbench checks
 * Xorshift source, reference product and word models, and typed
 * compare tasks with their error counters. Included inside the
 * testbench module.
 */

`ifndef ACCEL_TB_CHECKS_SVH
`define ACCEL_TB_CHECKS_SVH

// Error counters
int mismatch_count = 0;
int timeout_count  = 0;
int protocol_count = 0;

// Random state
logic [31:0] rng_state = 32'd65;

// --------------------
// Random numbers
// --------------------

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Advance the state and hand back the new word
task automatic draw_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
endtask

// --------------------
// Reference model
// --------------------

// Unsigned 8x8 product
function automatic logic [15:0] ref_product(input logic [7:0] a, input logic [7:0] b);
    logic [15:0] p;
    p = 16'(a) * 16'(b);
    return p;
endfunction

// Finished unit, busy clear and valid set
function automatic accel_pkg::t_mul2core ref_status(input logic [7:0] a,
                                                    input logic [7:0] b);
    accel_pkg::t_mul2core s;
    s.busy   = 1'b0;
    s.valid  = 1'b1;
    s.result = ref_product(a, b);
    return s;
endfunction

// Request CR keeps start, multiplicand and multiplier only
function automatic logic [31:0] ref_req_word(input logic [31:0] w);
    logic [31:0] r;
    r = 32'h0;
    r[`REQ_START_BIT:0] = w[`REQ_START_BIT:0];
    return r;
endfunction

// --------------------
// Compare tasks
// --------------------

task automatic compare_rsp(input string name, input accel_pkg::t_mul2core got,
                           input accel_pkg::t_mul2core exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
endtask

task automatic compare_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
endtask

`endif

//--- sim/accel_tb.sv
/*
 * Accelerator farm testbench
 * Drives the core register bus, checks CR read-back, and polls
 * the status CRs of all eight multiplier units
 */

`timescale 1ns/1ps

`include "accel_consts.svh"

module accel_tb;

    logic        Clk;
    logic        rst_n;
    logic [31:0] data;
    logic [31:0] address;
    logic        wren;
    logic        rden;
    logic [31:0] q;

    // Pending check handed to the comparing process
    event                 check_ev;
    bit                   chk_is_rsp;
    string                chk_name;
    logic [31:0]          chk_got_w, chk_exp_w;
    accel_pkg::t_mul2core chk_got_r, chk_exp_r;

    `include "accel_tb_checks.svh"

    accel_top i_accel_top (
        .Clk     (Clk),
        .rst_n   (rst_n),
        .data    (data),
        .address (address),
        .wren    (wren),
        .rden    (rden),
        .q       (q)
    );

    // 40 ns clock
    always #20 Clk = ~Clk;

    // Comparing process
    always begin
        @(check_ev);
        if (chk_is_rsp)
            compare_rsp(chk_name, chk_got_r, chk_exp_r);
        else
            compare_word(chk_name, chk_got_w, chk_exp_w);
    end

    // --------------------
    // Bus tasks
    // --------------------

    function automatic logic [31:0] req_addr(input int i);
        return 32'(`CR_CORE2MUL_BASE + `CR_STRIDE * i);
    endfunction

    function automatic logic [31:0] sts_addr(input int i);
        return 32'(`CR_MUL2CORE_BASE + `CR_STRIDE * i);
    endfunction

    // Strobe stays up until the next bus task, so writes can go back to back
    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        @(negedge Clk);
        address = a;
        data    = d;
        wren    = 1'b1;
        rden    = 1'b0;
        @(posedge Clk);
    endtask

    // q is registered, sampled at the following falling edge
    task automatic bus_read(input logic [31:0] a, output logic [31:0] w);
        @(negedge Clk);
        address = a;
        wren    = 1'b0;
        rden    = 1'b1;
        @(negedge Clk);
        rden = 1'b0;
        w    = q;
    endtask

    task automatic post_word(input string n, input logic [31:0] g, input logic [31:0] e);
        chk_is_rsp = 1'b0;
        chk_name   = n;
        chk_got_w  = g;
        chk_exp_w  = e;
        -> check_ev;
    endtask

    task automatic post_rsp(input string n, input accel_pkg::t_mul2core g,
                            input accel_pkg::t_mul2core e);
        chk_is_rsp = 1'b1;
        chk_name   = n;
        chk_got_r  = g;
        chk_exp_r  = e;
        -> check_ev;
    endtask

    // Read and check one word
    task automatic read_expect(input string n, input logic [31:0] a, input logic [31:0] e);
        logic [31:0] w;
        bus_read(a, w);
        post_word(n, w, e);
    endtask

    // Poll a status CR until the unit reports a finished product
    task automatic poll_status(input int u, input bit need_busy, input bit strict,
                               output accel_pkg::t_mul2core st);
        logic [31:0] w;
        bit          seen_busy;
        bit          done;
        int          n;
        seen_busy = 1'b0;
        done      = 1'b0;
        n         = 0;
        st        = '0;
        while (!done && n < 40) begin
            bus_read(sts_addr(u), w);
            st = accel_pkg::t_mul2core'(w[`RSP_BUSY_BIT:0]);
            if (st.busy && st.valid) begin
                protocol_count++;
                $display("Unit %0d shows busy and valid together at %0t", u, $time);
            end
            if (strict && st.valid && !seen_busy) begin
                protocol_count++;
                $display("Unit %0d shows valid before busy at %0t", u, $time);
            end
            if (st.busy)
                seen_busy = 1'b1;
            if (st.valid && !st.busy && (seen_busy || !need_busy))
                done = 1'b1;
            n++;
        end
        if (!done) begin
            timeout_count++;
            $display("Unit %0d never reported a finished product, gave up at %0t", u, $time);
        end
    endtask

    // Clear start, start with new operands, wait and check
    task automatic run_product(input int u, input logic [7:0] a, input logic [7:0] b);
        accel_pkg::t_mul2core st;
        bus_write(req_addr(u), {15'h0, 1'b0, a, b});
        bus_write(req_addr(u), {15'h0, 1'b1, a, b});
        poll_status(u, 1'b1, 1'b0, st);
        post_rsp($sformatf("status[%0d]", u), st, ref_status(a, b));
    endtask

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        logic [31:0]          r;
        logic [31:0]          wr_words [`ACCEL_NUM_MUL];
        logic [7:0]           ops_a [`ACCEL_NUM_MUL];
        logic [7:0]           ops_b [`ACCEL_NUM_MUL];
        accel_pkg::t_mul2core st;
        Clk     = 1'b0;
        rst_n   = 1'b0;
        data    = '0;
        address = '0;
        wren    = 1'b0;
        rden    = 1'b0;
        repeat (10) @(posedge Clk);
        @(negedge Clk);
        rst_n = 1'b1;

        // Everything clear after reset
        for (int i = 0; i < `ACCEL_NUM_MUL; i++) begin
            read_expect($sformatf("req_cr[%0d]", i), req_addr(i), 32'h0);
            read_expect($sformatf("sts_cr[%0d]", i), sts_addr(i), 32'h0);
        end

        // Busy seen before valid on a fresh unit
        bus_write(req_addr(0), {15'h0, 1'b1, 8'd13, 8'd11});
        poll_status(0, 1'b1, 1'b1, st);
        post_rsp("status[0]", st, ref_status(8'd13, 8'd11));

        // Request CR read-back
        for (int i = 0; i < `ACCEL_NUM_MUL; i++) begin
            draw_random(wr_words[i]);
            bus_write(req_addr(i), wr_words[i]);
        end
        for (int i = 0; i < `ACCEL_NUM_MUL; i++)
            read_expect($sformatf("req_cr[%0d]", i), req_addr(i), ref_req_word(wr_words[i]));

        // Ignored writes to status and unmapped addresses
        for (int i = 0; i < `ACCEL_NUM_MUL; i++) begin
            draw_random(r);
            bus_write(sts_addr(i), r);
        end
        bus_write(32'h0000_0020, 32'hffff_ffff);
        bus_write(32'h0000_0080, 32'hffff_ffff);
        for (int i = 0; i < `ACCEL_NUM_MUL; i++)
            read_expect($sformatf("req_cr[%0d]", i), req_addr(i), ref_req_word(wr_words[i]));
        read_expect("unmapped 0x20", 32'h0000_0020, 32'h0);
        read_expect("unmapped 0x80", 32'h0000_0080, 32'h0);
        read_expect("unmapped 0x3c", 32'h0000_003c, 32'h0);

        // Corner products, one unit each
        draw_random(r);
        run_product(0, 8'd0, r[7:0]);
        run_product(1, 8'd255, 8'd255);
        run_product(2, 8'd1, r[15:8]);
        run_product(3, r[23:16], 8'd0);
        run_product(4, r[31:24], 8'd1);
        for (int i = 5; i < `ACCEL_NUM_MUL; i++) begin
            draw_random(r);
            run_product(i, r[7:0], r[15:8]);
        end

        // All units at once with distinct operands
        for (int i = 0; i < `ACCEL_NUM_MUL; i++) begin
            draw_random(r);
            ops_a[i] = r[7:0];
            ops_b[i] = 8'(r[15:8] + i);
            bus_write(req_addr(i), {15'h0, 1'b0, ops_a[i], ops_b[i]});
        end
        for (int i = 0; i < `ACCEL_NUM_MUL; i++)
            bus_write(req_addr(i), {15'h0, 1'b1, ops_a[i], ops_b[i]});
        // Last unit started last, so it gates the others
        poll_status(`ACCEL_NUM_MUL - 1, 1'b1, 1'b0, st);
        post_rsp("status[7]", st, ref_status(ops_a[7], ops_b[7]));
        for (int i = 0; i < `ACCEL_NUM_MUL - 1; i++) begin
            poll_status(i, 1'b0, 1'b0, st);
            post_rsp($sformatf("status[%0d]", i), st, ref_status(ops_a[i], ops_b[i]));
        end

        // Start level held high while busy gives no restart
        bus_write(req_addr(5), {15'h0, 1'b0, 8'd200, 8'd3});
        bus_write(req_addr(5), {15'h0, 1'b1, 8'd200, 8'd3});
        bus_write(req_addr(5), {15'h0, 1'b1, 8'd7, 8'd9});
        poll_status(5, 1'b1, 1'b0, st);
        post_rsp("status[5]", st, ref_status(8'd200, 8'd3));
        run_product(5, 8'd7, 8'd9);

        @(negedge Clk);
        $display("Errors: mismatches=%0d timeouts=%0d protocol=%0d",
                 mismatch_count, timeout_count, protocol_count);
        if (mismatch_count + timeout_count + protocol_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
